// ==== Makefile ====
TOP = mulTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

# Pass only if the testbench printed its pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== dv/mulTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mulTb;
  import mulPkg::*;

  localparam int clkPeriod = 100;
  localparam int randomCount = 200;
  localparam int cornerCount = 7;
  localparam int backToBackCount = 100;
  localparam int plannedVectors = 2 * randomCount + 2 * cornerCount * cornerCount
                                  + backToBackCount;

  localparam logic [2:0] resetTest = 3'd0;
  localparam logic [2:0] unsignedTest = 3'd1;
  localparam logic [2:0] signedTest = 3'd2;
  localparam logic [2:0] cornerTest = 3'd3;
  localparam logic [2:0] backToBackTest = 3'd4;

  logic    mul_clk;
  logic    resetn;
  logic    mulSigned;
  operandT x;
  operandT y;
  productT result;

  // Previous-edge copy of the inputs
  operandT    prevX;
  operandT    prevY;
  logic       prevSigned;
  logic       prevResetn;
  logic [2:0] prevId;
  logic       primed = 1'b0;
  logic [2:0] testId;
  productT    expected;

  int errorCount = 0;

  operandT corners [cornerCount] = '{
    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
    32'h7fff_ffff, 32'haaaa_aaaa, 32'h5555_5555
  };

  mulTop dut (
    .mul_clk   (mul_clk),
    .resetn    (resetn),
    .mulSigned (mulSigned),
    .x         (x),
    .y         (y),
    .result    (result)
  );

  always #(clkPeriod / 2) mul_clk = ~mul_clk;

  // Full-width product, two's complement or unsigned
  function automatic productT productOf(input operandT a, input operandT b, input logic s);
    productT wideA;
    productT wideB;
    if (s) begin
      wideA = {{operandWidth{a[operandWidth-1]}}, a};
      wideB = {{operandWidth{b[operandWidth-1]}}, b};
    end else begin
      wideA = {{operandWidth{1'b0}}, a};
      wideB = {{operandWidth{1'b0}}, b};
    end
    return wideA * wideB;
  endfunction

  function automatic string nameOf(input logic [2:0] id);
    case (id)
      resetTest:      return "reset";
      unsignedTest:   return "unsigned";
      signedTest:     return "signed";
      cornerTest:     return "corner";
      default:        return "backToBack";
    endcase
  endfunction

  always @(posedge mul_clk) begin
    prevX      <= x;
    prevY      <= y;
    prevSigned <= mulSigned;
    prevResetn <= resetn;
    prevId     <= testId;
    primed     <= 1'b1;
  end

  assign expected = productOf(prevX, prevY, prevSigned);

  assert property (@(posedge mul_clk) (primed && !prevResetn) |-> result == '0)
    else begin
      errorCount++;
      $display("Error reset: expected %h actual %h", 64'h0, $sampled(result));
    end

  assert property (@(posedge mul_clk) (primed && prevResetn) |-> result == expected)
    else begin
      errorCount++;
      $display("Error %s: expected %h actual %h", nameOf($sampled(prevId)),
               $sampled(expected), $sampled(result));
    end

  // Drive one operation, then move to 1 ns past the next edge
  task automatic applyVector(input operandT a, input operandT b, input logic s,
                             input logic [2:0] id);
    x         = a;
    y         = b;
    mulSigned = s;
    testId    = id;
    @(posedge mul_clk);
    #1;
  endtask

  task automatic holdReset(input int cycles);
    resetn = 1'b0;
    testId = resetTest;
    repeat (cycles) begin
      @(posedge mul_clk);
      #1;
    end
    resetn = 1'b1;
  endtask

  initial begin
    logic [31:0] pick;
    logic        mode;
    mul_clk   = 1'b0;
    resetn    = 1'b0;
    mulSigned = 1'b0;
    x         = '0;
    y         = '0;
    testId    = resetTest;
    mode      = 1'b0;
    void'($urandom(32'hfbe1));

    holdReset(2);

    repeat (randomCount) applyVector($urandom(), $urandom(), 1'b0, unsignedTest);
    repeat (randomCount) applyVector($urandom(), $urandom(), 1'b1, signedTest);

    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < cornerCount; i++) begin
        for (int j = 0; j < cornerCount; j++) begin
          applyVector(corners[i], corners[j], s == 1, cornerTest);
        end
      end
    end

    // Mode flips and operands change every cycle, corners mixed in
    repeat (backToBackCount) begin
      pick = $urandom();
      mode = ~mode;
      if (pick[3:1] == 3'd0) begin
        applyVector(corners[pick[7:4] % cornerCount], $urandom(), mode, backToBackTest);
      end else begin
        applyVector($urandom(), $urandom(), mode, backToBackTest);
      end
    end

    // Reset again with a live product in the register
    holdReset(2);
    repeat (2) begin
      @(posedge mul_clk);
      #1;
    end

    $display("Run complete with %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #((plannedVectors + 10) * clkPeriod);
    $display("Timeout: the run did not finish in the expected time");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/boothArray.sv ====
`timescale 1ns/1ps
`default_nettype none

module boothArray (
  input  wire mulPkg::operandT x,
  input  wire mulPkg::operandT y,
  input  wire logic            mulSigned,
  partialProductIf.producer    pp
);
  import mulPkg::*;
  import boothPkg::*;

  extOperandT multiplicand;
  extOperandT multiplier;
  logic [extWidth:0] padded;
  productT [rowCount-1:0] rows;
  logic [rowCount-1:0] negCarry;

  // Sign or zero extension of both operands
  assign multiplicand = mulSigned ? {{(extWidth-operandWidth){x[operandWidth-1]}}, x}
                                  : {{(extWidth-operandWidth){1'b0}}, x};
  assign multiplier   = mulSigned ? {{(extWidth-operandWidth){y[operandWidth-1]}}, y}
                                  : {{(extWidth-operandWidth){1'b0}}, y};

  // Implicit zero below bit 0 for the first window
  assign padded = {multiplier, 1'b0};

  for (genvar i = 0; i < rowCount; i++) begin : gRow
    boothRow uRow (
      .multiplicand (multiplicand),
      .window       (padded[rowStep*i +: 3]),
      .shift        (6'(rowStep * i)),
      .row          (rows[i]),
      .negCarry     (negCarry[i])
    );
  end

  assign pp.rows     = rows;
  assign pp.negCarry = negCarry;

  // Top window is 000, 001 or 111 after extension
  always_comb begin
    assert final (!negCarry[rowCount-1])
      else $error("boothArray: top row chose a negative digit");
  end

endmodule

`default_nettype wire

// ==== src/boothPkg.sv ====
`default_nettype none

// Radix-4 Booth encoding
package boothPkg;

  // One row per two multiplier bits, plus one for the extension
  localparam int rowCount = 17;

  // Multiplier bits consumed per row
  localparam int rowStep = 2;

  // One bit per row in a tree column
  typedef logic [rowCount-1:0] columnT;

  // Three-bit overlapping window of the multiplier
  typedef logic [2:0] boothWindowT;

  typedef enum logic [2:0] {
    zero     = 3'd0,
    plusOne  = 3'd1,
    plusTwo  = 3'd2,
    minusTwo = 3'd3,
    minusOne = 3'd4
  } boothDigitT;

endpackage

`default_nettype wire

// ==== src/boothRow.sv ====
`timescale 1ns/1ps
`default_nettype none

module boothRow (
  input  wire mulPkg::extOperandT   multiplicand,
  input  wire boothPkg::boothWindowT window,
  input  wire logic [5:0]            shift,
  output mulPkg::productT            row,
  output logic                       negCarry
);
  import mulPkg::*;
  import boothPkg::*;

  boothDigitT digit;
  extOperandT inverted;
  extOperandT chosen;
  logic [productWidth+operandWidth-1:0] spread;

  always_comb begin
    case (window)
      3'b001, 3'b010: digit = plusOne;
      3'b011:         digit = plusTwo;
      3'b100:         digit = minusTwo;
      3'b101, 3'b110: digit = minusOne;
      default:        digit = zero;
    endcase
    negCarry = (digit == minusOne) || (digit == minusTwo);
    // Negative windows straight from the raw bits
    assert final (negCarry == (window[2] && !(window[1] && window[0])))
      else $error("boothRow: negation carry disagrees with window %b", window);
  end

  // One's complement only, the +1 arrives through negCarry
  assign inverted = ~multiplicand;

  always_comb begin
    case (digit)
      plusOne:  chosen = multiplicand;
      plusTwo:  chosen = {multiplicand[extWidth-2:0], 1'b0};
      minusTwo: chosen = {inverted[extWidth-2:0], 1'b1};
      minusOne: chosen = inverted;
      default:  chosen = '0;
    endcase
  end

  // Low fill of negCarry sits below the row once shifted
  assign spread = {{(productWidth-extWidth){chosen[extWidth-1]}}, chosen,
                   {operandWidth{negCarry}}} << shift;

  assign row = spread[productWidth+operandWidth-1:operandWidth];

endmodule

`default_nettype wire

// ==== src/finalStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module finalStage (
  input  wire                mul_clk,
  input  wire                resetn,
  partialProductIf.consumer  pp,
  input  wire mulPkg::productT sum,
  input  wire mulPkg::productT carry,
  output mulPkg::productT    result
);
  import mulPkg::*;

  productT sumReg;
  productT carryReg;
  logic    carryInReg;

  always_ff @(posedge mul_clk) begin
    if (!resetn) begin
      sumReg     <= '0;
      carryReg   <= '0;
      carryInReg <= 1'b0;
    end else begin
      sumReg     <= sum;
      // Column carries move up one place, negCarry 14 takes bit 0
      carryReg   <= {carry[productWidth-2:0], pp.negCarry[treeCarryWidth]};
      carryInReg <= pp.negCarry[treeCarryWidth+1];
    end
  end

  // Carry-propagate adder
  assign result = sumReg + carryReg + productT'(carryInReg);

  assert property (@(posedge mul_clk) !resetn |=> result == '0)
    else $error("finalStage: result not cleared after reset");

endmodule

`default_nettype wire

// ==== src/mulPkg.sv ====
`default_nettype none

// Operand, product and reduction-tree dimensions
package mulPkg;

  localparam int operandWidth = 32;

  // Two extra bits so the top Booth window sees a sign or zero
  localparam int extWidth = 34;

  localparam int productWidth = 64;

  // Carries passed from one Wallace column to the next
  localparam int treeCarryWidth = 14;

  typedef logic [operandWidth-1:0] operandT;

  typedef logic [extWidth-1:0] extOperandT;

  typedef logic [productWidth-1:0] productT;

  typedef logic [treeCarryWidth-1:0] columnCarryT;

endpackage

`default_nettype wire

// ==== src/mulTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mulTop (
  input  wire                   mul_clk,
  input  wire                   resetn,
  input  wire logic             mulSigned,
  input  wire mulPkg::operandT  x,
  input  wire mulPkg::operandT  y,
  output mulPkg::productT       result
);

  mulPkg::productT treeSum;
  mulPkg::productT treeCarry;

  partialProductIf pp ();

  boothArray uBooth (
    .x         (x),
    .y         (y),
    .mulSigned (mulSigned),
    .pp        (pp)
  );

  // Combinational reduction to sum and carry
  wallaceTree uTree (
    .pp    (pp),
    .sum   (treeSum),
    .carry (treeCarry)
  );

  finalStage uFinal (
    .mul_clk (mul_clk),
    .resetn  (resetn),
    .pp      (pp),
    .sum     (treeSum),
    .carry   (treeCarry),
    .result  (result)
  );

endmodule

`default_nettype wire

// ==== src/partialProductIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Booth rows and their negation carries
interface partialProductIf;
  import mulPkg::*;
  import boothPkg::*;

  productT [rowCount-1:0] rows;

  // Set where the row's digit is negative
  logic [rowCount-1:0] negCarry;

  modport producer (
    output rows,
    output negCarry
  );

  modport consumer (
    input rows,
    input negCarry
  );

endinterface

`default_nettype wire

// ==== src/wallaceColumn.sv ====
`timescale 1ns/1ps
`default_nettype none

module wallaceColumn (
  input  wire boothPkg::columnT     column,
  input  wire mulPkg::columnCarryT  carryIn,
  output mulPkg::columnCarryT       carryOut,
  output logic                      carry,
  output logic                      sum
);
  import mulPkg::*;
  import boothPkg::*;

  // Intermediate sums of the first fourteen adders
  logic [treeCarryWidth-1:0] s;

  // Returns {carry, sum}
  function automatic logic [1:0] fullAdd(input logic a, input logic b, input logic c);
    logic sumBit;
    logic carryBit;
    sumBit   = a ^ b ^ c;
    carryBit = (a & b) | (a & c) | (b & c);
    return {carryBit, sumBit};
  endfunction

  // First level, column bits 16 down to 2 in groups of three
  for (genvar k = 0; k < 5; k++) begin : gLevel0
    assign {carryOut[k], s[k]} = fullAdd(column[rowCount-1-3*k],
                                         column[rowCount-2-3*k],
                                         column[rowCount-3-3*k]);
  end

  assign {carryOut[5], s[5]} = fullAdd(s[0], s[1], s[2]);
  assign {carryOut[6], s[6]} = fullAdd(s[3], s[4], column[1]);
  assign {carryOut[7], s[7]} = fullAdd(column[0], carryIn[0], carryIn[1]);
  assign {carryOut[8], s[8]} = fullAdd(carryIn[2], carryIn[3], carryIn[4]);

  assign {carryOut[9], s[9]}   = fullAdd(s[5], s[6], s[7]);
  assign {carryOut[10], s[10]} = fullAdd(s[8], carryIn[5], carryIn[6]);

  assign {carryOut[11], s[11]} = fullAdd(s[9], s[10], carryIn[7]);
  assign {carryOut[12], s[12]} = fullAdd(carryIn[8], carryIn[9], carryIn[10]);

  assign {carryOut[13], s[13]} = fullAdd(s[11], s[12], carryIn[11]);

  // Last adder leaves the column as one sum and one carry
  assign {carry, sum} = fullAdd(s[13], carryIn[12], carryIn[13]);

endmodule

`default_nettype wire

// ==== src/wallaceTree.sv ====
`timescale 1ns/1ps
`default_nettype none

module wallaceTree (
  partialProductIf.consumer pp,
  output mulPkg::productT   sum,
  output mulPkg::productT   carry
);
  import mulPkg::*;
  import boothPkg::*;

  // Carry bundles between neighbouring columns
  columnCarryT chain [productWidth+1];

  // Column 0 absorbs the first fourteen negation carries
  assign chain[0] = pp.negCarry[treeCarryWidth-1:0];

  for (genvar j = 0; j < productWidth; j++) begin : gCol
    columnT bits;

    // Row 0 lands in the most significant bit
    for (genvar r = 0; r < rowCount; r++) begin : gBit
      assign bits[rowCount-1-r] = pp.rows[r][j];
    end

    wallaceColumn uCol (
      .column   (bits),
      .carryIn  (chain[j]),
      .carryOut (chain[j+1]),
      .carry    (carry[j]),
      .sum      (sum[j])
    );
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/mulPkg.sv
src/boothPkg.sv
src/partialProductIf.sv
src/boothRow.sv
src/boothArray.sv
src/wallaceColumn.sv
src/wallaceTree.sv
src/finalStage.sv
src/mulTop.sv
dv/mulTb.sv
